//--- Makefile
# Verilator build and run for the cache controller testbench

VERILATOR ?= verilator
TOP       ?= cache_ctrl_tb
FILELIST  ?= cache_ctrl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

PASS_MSG  := Simulation completed successfully
SOURCES   := $(shell grep -v '^+' $(FILELIST))
BINARY    := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message missing from $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/cache_ctrl_tb.sv
`timescale 1ns/10ps

module cache_ctrl_tb;

  import cache_ctrl_pkg::*;

  localparam int CLK_NS      = 4;
  localparam int RESET_CYC   = 8;
  localparam int N_RANDOM    = 200;
  localparam int N_REQ       = N_RANDOM + 4;
  localparam int WATCHDOG_NS = N_REQ * 30 * CLK_NS + RESET_CYC * CLK_NS;
  localparam int DONE_LIMIT  = 40;

  localparam logic [1:0] OP_WR   = 2'd1;
  localparam logic [1:0] OP_RD   = 2'd2;
  localparam logic [1:0] OP_FILL = 2'd3;

  typedef struct packed {
    logic [1:0]  kind;
    logic [15:0] addr;  // Memory address, or cache offset for a fill
    logic [7:0]  rel;   // Cycle after the accept edge
  } op_t;

  logic                clk;
  logic                arst_n;
  logic [ADDR_W-1:0]   addr;
  logic                read;
  logic                write;
  logic                hit;
  logic                valid;
  logic                dirty;
  logic [BANKS-1:0]    busy;
  logic [TAG_W-1:0]    cache_tag_in;
  cache_ctrl_t         cache;
  mem_req_t            mem;
  logic                done;
  logic                stall_cache;

  // Tag store model
  logic [TAG_W-1:0]    tag_mem [256];
  logic                valid_mem [256];
  logic                dirty_mem [256];

  op_t                 exp_q [$];
  int                  exp_done_rel = 0;
  logic                exp_is_write = 1'b0;
  logic [OFFSET_W-1:0] exp_offset = '0;
  logic [TAG_W-1:0]    exp_tag = '0;
  integer              seed;
  int                  edge_no = 0;
  int                  e0_edge = 0;
  logic                active = 1'b0;
  logic                timed_out = 1'b0;
  int                  accepted = 0;
  int                  done_count = 0;
  int                  value_errs = 0;
  int                  other_errs = 0;

  cache_ctrl_top dut (.*);

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // ******************************
  // Reference and checks
  // ******************************
  function automatic int expected_ops(input logic [ADDR_W-1:0] a, input logic h, input logic v,
                                      input logic d, input logic [TAG_W-1:0] victim,
                                      input int busy_len);
    int                 fill_start;
    logic [INDEX_W-1:0] idx;
    idx = a[10:3];
    if (h && v) begin
      return 2;
    end
    fill_start = 3;
    if (v && d) begin
      for (int k = 0; k < 4; k++) begin
        exp_q.push_back({OP_WR, {victim, idx, 2'(k), a[0]}, 8'(2 + k)});
      end
      fill_start = 7 + busy_len;  // Four writes, then busy wait
    end
    for (int j = 0; j < 6; j++) begin
      if (j < 4) exp_q.push_back({OP_RD, {a[15:11], idx, 2'(j), a[0]}, 8'(fill_start + j)});
      if (j >= 2) exp_q.push_back({OP_FILL, {13'd0, 2'(j - 2), a[0]}, 8'(fill_start + j)});
    end
    return fill_start + 7;
  endfunction

  task automatic report_value(input string name, input logic [15:0] exp, input logic [15:0] act);
    $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
    value_errs++;
  endtask

  task automatic match_op(input logic [1:0] kind, input logic [15:0] a, input int rel);
    op_t e;
    if (exp_q.size() == 0) begin
      $display("Operation of kind %0d at %0t ns was not expected", kind, $time);
      other_errs++;
    end else begin
      e = exp_q.pop_front();
      if (e.kind !== kind) report_value("operation kind", 16'(e.kind), 16'(kind));
      if (e.addr !== a) report_value(kind == OP_FILL ? "cache.offset" : "mem.address", e.addr, a);
      if (e.rel !== 8'(rel)) report_value("operation cycle", 16'(e.rel), 16'(rel));
    end
  endtask

  always @(posedge clk) begin : compare
    int         rel;
    logic [8:0] quiet;
    edge_no = edge_no + 1;
    rel     = edge_no - e0_edge;
    quiet   = {cache.enable, cache.comp, cache.c_write, cache.valid_in, cache.fill,
               mem.mem_wr, mem.mem_rd, done, stall_cache};
    if (done === 1'b1) done_count++;
    if (!active || rel <= 0 || rel > exp_done_rel) begin
      // First edge only applies the reset
      if (edge_no > 1 && quiet !== '0) report_value("idle controls", 16'd0, 16'(quiet));
    end else begin
      if (mem.mem_wr === 1'b1) match_op(OP_WR, mem.address, rel);
      if (mem.mem_rd === 1'b1) match_op(OP_RD, mem.address, rel);
      if (cache.fill === 1'b1) match_op(OP_FILL, 16'(cache.offset), rel);
      if (cache.fill === 1'b1 && {cache.enable, cache.c_write, cache.valid_in} !== 3'b111) begin
        report_value("fill enables", 16'h7,
                     16'({cache.enable, cache.c_write, cache.valid_in}));
      end
      if (cache.tag !== exp_tag) report_value("cache.tag", 16'(exp_tag), 16'(cache.tag));
      if (rel == 1) begin
        if (cache.comp !== 1'b1) report_value("cache.comp", 16'd1, 16'(cache.comp));
        if (cache.c_write !== exp_is_write) begin
          report_value("cache.c_write", 16'(exp_is_write), 16'(cache.c_write));
        end
      end
      if (rel == exp_done_rel - 1 && exp_done_rel > 2) begin  // FINAL of a miss
        if (cache.c_write !== exp_is_write) begin
          report_value("cache.c_write", 16'(exp_is_write), 16'(cache.c_write));
        end
        if (cache.valid_in !== exp_is_write) begin
          report_value("cache.valid_in", 16'(exp_is_write), 16'(cache.valid_in));
        end
        if (exp_is_write && cache.offset !== exp_offset) begin
          report_value("cache.offset", 16'(exp_offset), 16'(cache.offset));
        end
      end
      if (rel < exp_done_rel) begin
        if (stall_cache !== 1'b1) report_value("stall_cache", 16'd1, 16'(stall_cache));
        if (done !== 1'b0) report_value("done", 16'd0, 16'(done));
      end else begin
        if (done !== 1'b1) report_value("done", 16'd1, 16'(done));
        if (stall_cache !== 1'b0) report_value("stall_cache", 16'd0, 16'(stall_cache));
        if (exp_q.size() != 0) begin
          $display("%0d expected operations were missing at done", exp_q.size());
          other_errs++;
        end
      end
    end
  end

  // ******************************
  // Stimulus
  // ******************************
  task automatic run_request(input logic [ADDR_W-1:0] a, input logic wr, input int busy_len,
                             input logic noisy, input int gap);
    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   tg;
    logic               h;
    logic               v;
    logic               d;
    logic [31:0]        r;
    int                 c;
    idx = a[10:3];
    tg  = a[15:11];
    h   = (tag_mem[idx] == tg);
    v   = valid_mem[idx];
    d   = dirty_mem[idx];
    r   = $random(seed);
    exp_q.delete();
    exp_done_rel = expected_ops(a, h, v, d, tag_mem[idx], busy_len);
    exp_is_write = wr;
    exp_offset   = a[2:0];
    exp_tag      = tg;
    addr         = a;
    write        = wr;
    read         = ~wr | (noisy & r[0]);  // Both high on some writes
    hit          = h;
    valid        = v;
    dirty        = d;
    cache_tag_in = tag_mem[idx];
    e0_edge      = edge_no + 1;
    active       = 1'b1;
    accepted++;
    c = 0;
    do begin
      @(negedge clk);
      c++;
      r = $random(seed);
      busy = (v && d && !h && c >= 6 && c <= 5 + busy_len) ? (4'b0001 << r[1:0]) | r[5:2] : '0;
      if (!stall_cache) begin
        read  = 1'b0;
        write = 1'b0;
      end else if (noisy) begin
        addr  = r[31:16];  // Must be ignored
        read  = r[6];
        write = r[7];
      end
    end while (done !== 1'b1 && c < DONE_LIMIT);
    if (done !== 1'b1) begin
      $display("Request %0d at 0x%h raised no done within %0d cycles", accepted, a, DONE_LIMIT);
      other_errs++;
      timed_out = 1'b1;
    end else begin
      if (h && v) begin
        dirty_mem[idx] = dirty_mem[idx] | wr;
      end else begin
        tag_mem[idx]   = tg;
        valid_mem[idx] = 1'b1;
        dirty_mem[idx] = wr;
      end
      @(negedge clk);
      repeat (gap) @(negedge clk);
    end
  endtask

  task automatic finish_run();
    $display("Errors: %0d value, %0d other; requests %0d, done pulses %0d",
             value_errs, other_errs, accepted, done_count);
    if (value_errs + other_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  initial begin : stimulus
    logic [31:0] r;
    seed         = 32'hf635;
    arst_n       = 1'b0;
    addr         = '0;
    read         = 1'b0;
    write        = 1'b0;
    hit          = 1'b0;
    valid        = 1'b0;
    dirty        = 1'b0;
    busy         = '0;
    cache_tag_in = '0;
    for (int i = 0; i < 256; i++) begin
      tag_mem[8'(i)]   = 5'(i ^ (i >> 4) ^ 3);
      valid_mem[8'(i)] = 1'b0;
      dirty_mem[8'(i)] = 1'b0;
    end
    repeat (RESET_CYC) @(negedge clk);
    arst_n = 1'b1;
    repeat (3) @(negedge clk);

    run_request(16'h2a2c, 1'b0, 0, 1'b0, 0);                  // Clean read miss
    if (!timed_out) run_request(16'h2a2c, 1'b0, 0, 1'b0, 1);  // Read hit
    if (!timed_out) run_request(16'h2a2e, 1'b1, 0, 1'b0, 0);  // Write hit, line now dirty
    if (!timed_out) run_request(16'h7a2d, 1'b1, 3, 1'b0, 2);  // Dirty write miss, same index

    // Few tags over few lines for a mix of hits and misses
    for (int i = 0; i < N_RANDOM && !timed_out; i++) begin
      r = $random(seed);
      run_request({3'b101, r[1:0], 5'b01100, r[4:2], r[7:5]}, r[8], int'(r[11:9]) % 6,
                  1'b1, int'(r[13:12]));
    end

    if (done_count != accepted) begin
      $display("Done pulses %0d differ from accepted requests %0d", done_count, accepted);
      other_errs++;
    end
    finish_run();
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before all requests finished", WATCHDOG_NS);
    other_errs++;
    finish_run();
  end

endmodule

//--- cache_ctrl.f
common/cache_ctrl_pkg.sv
src/req_capture.sv
cache_fsm/cache_fsm.sv
src/access_gen.sv
src/cache_ctrl_top.sv
bench/cache_ctrl_tb.sv

//--- cache_fsm/cache_fsm.sv
`timescale 1ns/10ps

module cache_fsm (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            start,
  input  logic                            is_write,
  input  logic                            hit,
  input  logic                            valid,
  input  logic                            dirty,
  input  logic [cache_ctrl_pkg::BANKS-1:0] busy,
  output logic                            idle,
  output cache_ctrl_pkg::burst_cmd_t      cmd,
  output logic                            done,
  output logic                            stall_cache
);

  import cache_ctrl_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_nxt;
  logic [2:0]  cnt;
  logic [2:0]  cnt_nxt;
  logic        victim_dirty;
  logic        wb_last;
  logic        fill_last;

  assign victim_dirty = valid & dirty & ~hit;
  assign wb_last      = (cnt == 3'(WORDS_PER_LINE - 1));
  assign fill_last    = (cnt == 3'(FILL_LEN - 1));

  // ******************************
  // Next state
  // ******************************
  always_comb begin
    state_nxt = state;
    cnt_nxt   = cnt + 3'd1;
    case (state)
      IDLE: begin
        cnt_nxt = '0;
        if (start) begin
          state_nxt = COMP;
        end
      end
      COMP: begin
        cnt_nxt = '0;
        if (hit & valid) begin
          state_nxt = DONE;
        end else begin
          // Every miss allocates the line
          state_nxt = victim_dirty ? WRITE_BACK : WB_WAIT;
        end
      end
      WRITE_BACK: begin
        if (wb_last) begin
          state_nxt = WB_WAIT;
          cnt_nxt   = '0;
        end
      end
      WB_WAIT: begin
        cnt_nxt = '0;
        if (busy == '0) begin  // All banks free
          state_nxt = FILL;
        end
      end
      FILL: begin
        if (fill_last) begin
          state_nxt = FINAL;
          cnt_nxt   = '0;
        end
      end
      FINAL: begin
        cnt_nxt   = '0;
        state_nxt = DONE;
      end
      DONE: begin
        cnt_nxt   = '0;
        state_nxt = IDLE;
      end
      default: begin
        cnt_nxt   = '0;
        state_nxt = IDLE;
      end
    endcase
  end

  // ******************************
  // State and counter
  // ******************************
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      cnt   <= cnt_nxt;
    end
  end

  // Outputs decoded from state only
  assign idle        = (state == IDLE);
  assign done        = (state == DONE);
  assign stall_cache = (state != IDLE) && (state != DONE);

  assign cmd.phase = state;
  assign cmd.count = cnt;

endmodule

//--- common/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

  // ******************************
  // Address fields
  // ******************************
  localparam int ADDR_W   = 16;
  localparam int TAG_W    = 5;   // addr[15:11]
  localparam int INDEX_W  = 8;   // addr[10:3]
  localparam int OFFSET_W = 3;   // addr[2:1] word, addr[0] byte

  localparam int WORDS_PER_LINE = 4;
  localparam int BANKS          = 4;

  // Memory read to cache write distance
  localparam int MEM_LATENCY = 2;
  localparam int FILL_LEN    = WORDS_PER_LINE + MEM_LATENCY;

  // ******************************
  // Types
  // ******************************
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              is_write;
  } cache_req_t;

  typedef enum logic [2:0] {
    IDLE,
    COMP,
    WRITE_BACK,
    WB_WAIT,
    FILL,
    FINAL,
    DONE
  } ctrl_state_e;

  typedef struct packed {
    ctrl_state_e phase;
    logic [2:0]  count;  // Word counter inside a burst
  } burst_cmd_t;

  // Cache array side
  typedef struct packed {
    logic                enable;
    logic                comp;
    logic                c_write;
    logic                valid_in;
    logic                fill;     // Memory data into cache
    logic [TAG_W-1:0]    tag;
    logic [OFFSET_W-1:0] offset;
  } cache_ctrl_t;

  // Banked memory side
  typedef struct packed {
    logic              mem_wr;
    logic              mem_rd;
    logic [ADDR_W-1:0] address;
  } mem_req_t;

endpackage

//--- src/access_gen.sv
`timescale 1ns/10ps

module access_gen (
  input  cache_ctrl_pkg::cache_req_t       req,
  input  cache_ctrl_pkg::burst_cmd_t       cmd,
  input  logic [cache_ctrl_pkg::TAG_W-1:0] cache_tag_in,
  output cache_ctrl_pkg::cache_ctrl_t      cache,
  output cache_ctrl_pkg::mem_req_t         mem
);

  import cache_ctrl_pkg::*;

  logic [TAG_W-1:0]   req_tag;
  logic [INDEX_W-1:0] req_index;
  logic               req_byte;
  logic [1:0]         word_k;
  logic [2:0]         fill_cnt;
  logic [1:0]         fill_word;

  assign req_tag   = req.addr[ADDR_W-1 -: TAG_W];
  assign req_index = req.addr[OFFSET_W +: INDEX_W];
  assign req_byte  = req.addr[0];
  assign word_k    = cmd.count[1:0];

  // Cache side trails memory reads
  assign fill_cnt  = cmd.count - 3'(MEM_LATENCY);
  assign fill_word = fill_cnt[1:0];

  always_comb begin
    cache        = '0;
    cache.tag    = req_tag;
    cache.offset = req.addr[OFFSET_W-1:0];
    mem          = '0;
    mem.address  = req.addr;

    case (cmd.phase)
      COMP: begin
        cache.enable  = 1'b1;
        cache.comp    = 1'b1;
        cache.c_write = req.is_write;  // Write hit lands here
      end
      WRITE_BACK: begin
        // Victim line out, word by word
        cache.enable = 1'b1;
        cache.offset = {word_k, req_byte};
        mem.mem_wr   = 1'b1;
        mem.address  = {cache_tag_in, req_index, word_k, req_byte};
      end
      FILL: begin
        if (cmd.count < 3'(WORDS_PER_LINE)) begin
          mem.mem_rd  = 1'b1;
          mem.address = {req_tag, req_index, word_k, req_byte};
        end
        if (cmd.count >= 3'(MEM_LATENCY)) begin
          cache.enable   = 1'b1;
          cache.c_write  = 1'b1;
          cache.valid_in = 1'b1;
          cache.fill     = 1'b1;
          cache.offset   = {fill_word, req_byte};
        end
      end
      FINAL: begin
        cache.enable   = 1'b1;
        cache.c_write  = req.is_write;
        cache.valid_in = req.is_write;
      end
      WB_WAIT, DONE: begin
        cache.enable = 1'b1;
      end
      default: begin
        cache.enable = 1'b0;  // Idle, array quiet
      end
    endcase
  end

endmodule

//--- src/cache_ctrl_top.sv
`timescale 1ns/10ps

module cache_ctrl_top (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic [cache_ctrl_pkg::ADDR_W-1:0] addr,
  input  logic                             read,
  input  logic                             write,
  input  logic                             hit,
  input  logic                             valid,
  input  logic                             dirty,
  input  logic [cache_ctrl_pkg::BANKS-1:0]  busy,
  input  logic [cache_ctrl_pkg::TAG_W-1:0]  cache_tag_in,
  output cache_ctrl_pkg::cache_ctrl_t      cache,
  output cache_ctrl_pkg::mem_req_t         mem,
  output logic                             done,
  output logic                             stall_cache
);

  import cache_ctrl_pkg::*;

  logic       idle;
  logic       start;
  cache_req_t req;
  burst_cmd_t cmd;

  req_capture u_req_capture (
    .clk    (clk),
    .arst_n (arst_n),
    .addr   (addr),
    .read   (read),
    .write  (write),
    .idle   (idle),
    .start  (start),
    .req    (req)
  );

  cache_fsm u_cache_fsm (
    .clk         (clk),
    .arst_n      (arst_n),
    .start       (start),
    .is_write    (req.is_write),
    .hit         (hit),
    .valid       (valid),
    .dirty       (dirty),
    .busy        (busy),
    .idle        (idle),
    .cmd         (cmd),
    .done        (done),
    .stall_cache (stall_cache)
  );

  access_gen u_access_gen (
    .req          (req),
    .cmd          (cmd),
    .cache_tag_in (cache_tag_in),
    .cache        (cache),
    .mem          (mem)
  );

endmodule

//--- src/req_capture.sv
`timescale 1ns/10ps

module req_capture (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic [cache_ctrl_pkg::ADDR_W-1:0] addr,
  input  logic                             read,
  input  logic                             write,
  input  logic                             idle,
  output logic                             start,
  output cache_ctrl_pkg::cache_req_t       req
);

  import cache_ctrl_pkg::*;

  // Only one request in flight, accept while idle
  assign start = idle & (read | write);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req <= '0;
    end else if (start) begin
      req.addr     <= addr;
      req.is_write <= write;  // Write wins over read
    end
  end

endmodule
